// ==== sources.f ====
source/downscale_pkg.sv
source/pixel_stream_if.sv
source/uart_rx.sv
source/uart_tx.sv
source/raster_counter.sv
source/pixel_pair_sum.sv
source/line_pair_buffer.sv
source/block_average.sv
source/downscale_top.sv
tests/tb_downscale_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --top-module tb_downscale_top -f sources.f

./obj_dir/Vtb_downscale_top | tee sim.log

if grep -q "^RESULT: PASS$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// ==== tests/tb_downscale_top.sv ====
`timescale 1ns/1ps

module tb_downscale_top;

    localparam int CLKS_PER_BAUD = 8;
    localparam int IMG_W = 8;
    localparam int IMG_H = 4;
    localparam int FRAME_PIX = IMG_W * IMG_H;
    localparam int BIT_NS = CLKS_PER_BAUD * 10;
    localparam int N_FRAMES = 6;
    localparam int TIMEOUT_NS = N_FRAMES * FRAME_PIX * 10 * BIT_NS + 20000;
    localparam int FILL_RAMP = 0;
    localparam int FILL_RANDOM = 1;
    localparam int FILL_FLAT = 2;

    logic       clk_100mhz = 1'b0;
    logic       arst_n;
    logic       uart_rxd;
    logic       uart_txd;
    logic       frame_done;
    logic       frame_err;
    logic [7:0] frame [FRAME_PIX];
    logic [7:0] exp_q [$];    // expected output bytes
    logic [7:0] rx_q [$];     // bytes decoded from uart_txd
    int         seed;
    int         exp_total = 0;
    int         got_count = 0;
    int         done_cnt = 0;
    int         err_cnt = 0;

    downscale_top #(
        .CLKS_PER_BAUD (CLKS_PER_BAUD),
        .IMG_WIDTH     (IMG_W),
        .IMG_HEIGHT    (IMG_H)
    ) downscale_top_i (
        .clk_100mhz   (clk_100mhz),
        .arst_n_i     (arst_n),
        .uart_rxd_i   (uart_rxd),
        .uart_txd_o   (uart_txd),
        .frame_done_o (frame_done),
        .frame_err_o  (frame_err)
    );

    always #5 clk_100mhz = ~clk_100mhz;

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
            stop_with_failure("value mismatch");
        end
    endtask

    // average of one 2x2 block, block coordinates in the output image
    function automatic logic [7:0] block_avg_ref(input logic [7:0] img [FRAME_PIX],
                                                 input int bx, input int by);
        int top_left;
        int sum;
        top_left = 2 * by * IMG_W + 2 * bx;
        sum = int'(img[top_left]) + int'(img[top_left + 1])
            + int'(img[top_left + IMG_W]) + int'(img[top_left + IMG_W + 1]);
        return 8'(sum / 4);
    endfunction

    task automatic fill_frame(input int kind, input logic [7:0] level);
        for (int y = 0; y < IMG_H; y++) begin
            for (int x = 0; x < IMG_W; x++) begin
                if (kind == FILL_RAMP) begin
                    frame[y * IMG_W + x] = 8'(x + 8 * y);
                end else if (kind == FILL_RANDOM) begin
                    frame[y * IMG_W + x] = 8'($random(seed));
                end else begin
                    frame[y * IMG_W + x] = level;
                end
            end
        end
    endtask

    // bits change 1 ns after the rising edge, each bit lasts one baud period
    task automatic send_byte(input logic [7:0] value, input logic stop_bit);
        logic [9:0] bits;
        bits = {stop_bit, value, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge clk_100mhz);
            #1;
            uart_rxd = bits[i];
            repeat (CLKS_PER_BAUD - 1) @(posedge clk_100mhz);
        end
        if (!stop_bit) begin   // back to idle so the next start bit has a falling edge
            @(posedge clk_100mhz);
            #1;
            uart_rxd = 1'b1;
            repeat (CLKS_PER_BAUD - 1) @(posedge clk_100mhz);
        end
    endtask

    // bad_idx selects a pixel that goes out once with a low stop bit first
    task automatic send_frame(input int bad_idx);
        for (int by = 0; by < IMG_H / 2; by++) begin
            for (int bx = 0; bx < IMG_W / 2; bx++) begin
                exp_q.push_back(block_avg_ref(frame, bx, by));
                exp_total++;
            end
        end
        for (int i = 0; i < FRAME_PIX; i++) begin
            if (i == bad_idx) begin
                send_byte(frame[i], 1'b0);
            end
            send_byte(frame[i], 1'b1);
        end
    endtask

    task automatic wait_drained();
        wait (got_count == exp_total);
        repeat (20 * CLKS_PER_BAUD) @(posedge clk_100mhz);   // room for stray bytes
    endtask

    // uart monitor, samples each bit in its middle
    initial begin
        logic [7:0] data;
        forever begin
            @(negedge uart_txd);
            #(BIT_NS / 2);
            for (int i = 0; i < 8; i++) begin
                #(BIT_NS);
                data[i] = uart_txd;
            end
            #(BIT_NS);
            if (uart_txd !== 1'b1) begin
                stop_with_failure("the stop bit on uart_txd_o was not high");
            end
            rx_q.push_back(data);
        end
    end

    initial begin
        logic [7:0] got;
        forever begin
            wait (rx_q.size() != 0);
            got = rx_q.pop_front();
            if (exp_q.size() == 0) begin
                stop_with_failure("uart_txd_o sent a byte that was not expected");
            end
            check_value("uart_txd_o byte", 32'(got), 32'(exp_q.pop_front()));
            got_count++;
        end
    end

    always @(posedge clk_100mhz) begin
        if (frame_done) done_cnt <= done_cnt + 1;
        if (frame_err) err_cnt <= err_cnt + 1;
    end

    initial begin
        #(TIMEOUT_NS);
        stop_with_failure("the simulation timed out before all output bytes arrived");
    end

    initial begin
        seed = 20048;
        uart_rxd = 1'b1;
        arst_n = 1'b0;
        repeat (16) @(posedge clk_100mhz);
        #1;
        arst_n = 1'b1;

        // idle line after reset
        repeat (200) begin
            @(posedge clk_100mhz);
            #1;
            check_value("uart_txd_o", 32'(uart_txd), 32'(1));
            check_value("frame_done_o", 32'(frame_done), 32'(0));
            check_value("frame_err_o", 32'(frame_err), 32'(0));
        end

        fill_frame(FILL_RAMP, 8'h00);
        send_frame(-1);
        wait_drained();
        check_value("frame_done_o pulses", 32'(done_cnt), 32'(1));

        for (int f = 0; f < 2; f++) begin   // back to back random frames
            fill_frame(FILL_RANDOM, 8'h00);
            send_frame(-1);
        end
        wait_drained();
        check_value("frame_done_o pulses", 32'(done_cnt), 32'(3));

        fill_frame(FILL_FLAT, 8'hff);
        send_frame(-1);
        fill_frame(FILL_FLAT, 8'h00);
        send_frame(-1);
        wait_drained();
        check_value("frame_done_o pulses", 32'(done_cnt), 32'(5));
        check_value("frame_err_o pulses", 32'(err_cnt), 32'(0));

        fill_frame(FILL_RANDOM, 8'h00);
        send_frame(11);
        wait_drained();
        check_value("frame_err_o pulses", 32'(err_cnt), 32'(1));
        check_value("frame_done_o pulses", 32'(done_cnt), 32'(6));

        $display("RESULT: PASS");
        $finish;
    end

endmodule

// ==== source/downscale_top.sv ====
`timescale 1ns/1ps

module downscale_top import downscale_pkg::*; #(
    parameter int CLKS_PER_BAUD = 33,
    parameter int IMG_WIDTH     = 64,
    parameter int IMG_HEIGHT    = 64
) (
    input  logic clk_100mhz,
    input  logic arst_n_i,
    input  logic uart_rxd_i,
    output logic uart_txd_o,
    output logic frame_done_o,
    output logic frame_err_o
);

    pixel_t    rx_data;
    logic      rx_valid;
    pair_sum_t row_sum;
    logic      row_valid;
    pair_sum_t line_sum;
    logic      line_valid;
    pixel_t    tx_data;
    logic      tx_start;

    pixel_stream_if pixel_stream ();   // coordinate tagged input pixels

    uart_rx #(.CLKS_PER_BAUD(CLKS_PER_BAUD)) uart_rx_i (
        .clk_100mhz  (clk_100mhz),
        .arst_n_i    (arst_n_i),
        .rxd_i       (uart_rxd_i),
        .data_o      (rx_data),
        .valid_o     (rx_valid),
        .frame_err_o (frame_err_o)
    );

    raster_counter #(
        .IMG_WIDTH  (IMG_WIDTH),
        .IMG_HEIGHT (IMG_HEIGHT)
    ) raster_counter_i (
        .clk_100mhz   (clk_100mhz),
        .arst_n_i     (arst_n_i),
        .data_i       (rx_data),
        .valid_i      (rx_valid),
        .stream_o     (pixel_stream.source),
        .frame_done_o (frame_done_o)
    );

    // these two run side by side on the same stream
    pixel_pair_sum pixel_pair_sum_i (
        .clk_100mhz  (clk_100mhz),
        .arst_n_i    (arst_n_i),
        .stream_i    (pixel_stream.sink),
        .sum_o       (row_sum),
        .sum_valid_o (row_valid)
    );

    line_pair_buffer #(.IMG_WIDTH(IMG_WIDTH)) line_pair_buffer_i (
        .clk_100mhz  (clk_100mhz),
        .arst_n_i    (arst_n_i),
        .stream_i    (pixel_stream.sink),
        .sum_o       (line_sum),
        .sum_valid_o (line_valid)
    );

    block_average block_average_i (
        .clk_100mhz   (clk_100mhz),
        .arst_n_i     (arst_n_i),
        .row_sum_i    (row_sum),
        .row_valid_i  (row_valid),
        .line_sum_i   (line_sum),
        .line_valid_i (line_valid),
        .tx_data_o    (tx_data),
        .tx_start_o   (tx_start)
    );

    uart_tx #(.CLKS_PER_BAUD(CLKS_PER_BAUD)) uart_tx_i (
        .clk_100mhz (clk_100mhz),
        .arst_n_i   (arst_n_i),
        .data_i     (tx_data),
        .start_i    (tx_start),
        .busy_o     (),   // never busy when a new start arrives
        .txd_o      (uart_txd_o)
    );

endmodule

// ==== source/block_average.sv ====
`timescale 1ns/1ps

module block_average import downscale_pkg::*; (
    input  logic      clk_100mhz,
    input  logic      arst_n_i,
    input  pair_sum_t row_sum_i,
    input  logic      row_valid_i,
    input  pair_sum_t line_sum_i,
    input  logic      line_valid_i,
    output pixel_t    tx_data_o,
    output logic      tx_start_o
);

    pair_sum_t  line_term;
    block_sum_t block_sum;

    // both valids come in the same cycle, the line sum only counts when it is valid
    assign line_term = line_valid_i ? line_sum_i : '0;

    assign block_sum = block_sum_t'(row_sum_i) + block_sum_t'(line_term);

    always_ff @(posedge clk_100mhz) begin
        if (row_valid_i) begin
            tx_data_o <= block_sum[BLOCK_SUM_W-1:2];   // divide by four, rounded down
        end
    end

    always_ff @(posedge clk_100mhz or negedge arst_n_i) begin
        if (!arst_n_i) begin
            tx_start_o <= 1'b0;
        end else begin
            tx_start_o <= row_valid_i;   // single cycle start for the transmitter
        end
    end

endmodule

// ==== source/line_pair_buffer.sv ====
`timescale 1ns/1ps

module line_pair_buffer import downscale_pkg::*; #(
    parameter int IMG_WIDTH = 64
) (
    input  logic           clk_100mhz,
    input  logic           arst_n_i,
    pixel_stream_if.sink   stream_i,
    output pair_sum_t      sum_o,
    output logic           sum_valid_o
);

    localparam int ADDR_W = $clog2(IMG_WIDTH);

    pixel_t            line_mem [IMG_WIDTH];   // one full even row
    logic [ADDR_W-1:0] addr;
    logic [ADDR_W-1:0] even_addr;
    logic              wr_en;
    logic              rd_en;

    assign addr      = stream_i.x[ADDR_W-1:0];
    assign even_addr = addr & ~ADDR_W'(1);   // left pixel of the pair

    assign wr_en = stream_i.valid && !stream_i.y[0];
    assign rd_en = stream_i.valid && stream_i.y[0] && stream_i.x[0];

    always_ff @(posedge clk_100mhz) begin
        if (wr_en) begin
            line_mem[addr] <= stream_i.pix;
        end
    end

    // asynchronous read, so the sum lines up with the pair summer
    always_ff @(posedge clk_100mhz) begin
        if (rd_en) begin
            sum_o <= pair_sum_t'(line_mem[even_addr]) + pair_sum_t'(line_mem[addr]);
        end
    end

    always_ff @(posedge clk_100mhz or negedge arst_n_i) begin
        if (!arst_n_i) begin
            sum_valid_o <= 1'b0;
        end else begin
            sum_valid_o <= rd_en;
        end
    end

endmodule

// ==== source/pixel_pair_sum.sv ====
`timescale 1ns/1ps

module pixel_pair_sum import downscale_pkg::*; (
    input  logic           clk_100mhz,
    input  logic           arst_n_i,
    pixel_stream_if.sink   stream_i,
    output pair_sum_t      sum_o,
    output logic           sum_valid_o
);

    pixel_t even_pix;   // left pixel of the current pair
    logic   take_even;
    logic   take_odd;

    // only odd rows matter, the even row goes to the line buffer
    assign take_even = stream_i.valid && stream_i.y[0] && !stream_i.x[0];
    assign take_odd  = stream_i.valid && stream_i.y[0] && stream_i.x[0];

    always_ff @(posedge clk_100mhz) begin
        if (take_even) begin
            even_pix <= stream_i.pix;
        end
        if (take_odd) begin
            sum_o <= pair_sum_t'(even_pix) + pair_sum_t'(stream_i.pix);
        end
    end

    always_ff @(posedge clk_100mhz or negedge arst_n_i) begin
        if (!arst_n_i) begin
            sum_valid_o <= 1'b0;
        end else begin
            sum_valid_o <= take_odd;   // one cycle after the stream strobe
        end
    end

endmodule

// ==== source/raster_counter.sv ====
`timescale 1ns/1ps

module raster_counter import downscale_pkg::*; #(
    parameter int IMG_WIDTH  = 64,
    parameter int IMG_HEIGHT = 64
) (
    input  logic                  clk_100mhz,
    input  logic                  arst_n_i,
    input  pixel_t                data_i,
    input  logic                  valid_i,
    pixel_stream_if.source        stream_o,
    output logic                  frame_done_o
);

    coord_t x_cnt;    // column of the next byte
    coord_t y_cnt;    // row of the next byte
    logic   last_col;
    logic   last_row;

    assign last_col = (x_cnt == coord_t'(IMG_WIDTH - 1));
    assign last_row = (y_cnt == coord_t'(IMG_HEIGHT - 1));

    always_ff @(posedge clk_100mhz or negedge arst_n_i) begin
        if (!arst_n_i) begin
            x_cnt          <= '0;
            y_cnt          <= '0;
            stream_o.pix   <= '0;
            stream_o.x     <= '0;
            stream_o.y     <= '0;
            stream_o.valid <= 1'b0;
            frame_done_o   <= 1'b0;
        end else begin
            stream_o.valid <= valid_i;
            frame_done_o   <= valid_i && last_col && last_row;   // with the last pixel
            if (valid_i) begin
                stream_o.pix <= data_i;
                stream_o.x   <= x_cnt;
                stream_o.y   <= y_cnt;
                if (last_col) begin
                    x_cnt <= '0;
                    y_cnt <= last_row ? coord_t'(0) : y_cnt + coord_t'(1);
                end else begin
                    x_cnt <= x_cnt + coord_t'(1);
                end
            end
        end
    end

endmodule

// ==== source/uart_tx.sv ====
`timescale 1ns/1ps

module uart_tx import downscale_pkg::*; #(
    parameter int CLKS_PER_BAUD = 33
) (
    input  logic   clk_100mhz,
    input  logic   arst_n_i,
    input  pixel_t data_i,
    input  logic   start_i,
    output logic   busy_o,
    output logic   txd_o
);

    localparam int CNT_W = $clog2(CLKS_PER_BAUD + 1);

    uart_state_e      state;
    logic [CNT_W-1:0] baud_cnt;
    logic [2:0]       bit_idx;
    pixel_t           shift_reg;
    logic             baud_end;

    assign baud_end = (baud_cnt == CNT_W'(CLKS_PER_BAUD - 1));

    always_ff @(posedge clk_100mhz or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state     <= UART_IDLE;
            baud_cnt  <= '0;
            bit_idx   <= '0;
            shift_reg <= '0;
            txd_o     <= 1'b1;   // line idles high
        end else begin
            case (state)
                UART_IDLE: begin
                    if (start_i) begin
                        shift_reg <= data_i;
                        baud_cnt  <= '0;
                        txd_o     <= 1'b0;   // start bit from the next cycle on
                        state     <= UART_START;
                    end
                end
                UART_START: begin
                    if (baud_end) begin
                        baud_cnt  <= '0;
                        bit_idx   <= '0;
                        txd_o     <= shift_reg[0];
                        shift_reg <= shift_reg >> 1;
                        state     <= UART_DATA;
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                UART_DATA: begin
                    if (baud_end) begin
                        baud_cnt <= '0;
                        bit_idx  <= bit_idx + 3'd1;
                        if (bit_idx == 3'd7) begin
                            txd_o <= 1'b1;   // stop bit
                            state <= UART_STOP;
                        end else begin
                            txd_o     <= shift_reg[0];
                            shift_reg <= shift_reg >> 1;
                        end
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                UART_STOP: begin
                    if (baud_end) begin
                        baud_cnt <= '0;
                        state    <= UART_IDLE;
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                default: state <= UART_IDLE;
            endcase
        end
    end

    assign busy_o = (state != UART_IDLE);

endmodule

// ==== source/uart_rx.sv ====
`timescale 1ns/1ps

module uart_rx import downscale_pkg::*; #(
    parameter int CLKS_PER_BAUD = 33
) (
    input  logic   clk_100mhz,
    input  logic   arst_n_i,
    input  logic   rxd_i,
    output pixel_t data_o,
    output logic   valid_o,
    output logic   frame_err_o
);

    localparam int CNT_W = $clog2(CLKS_PER_BAUD + 1);
    localparam int HALF_BAUD = CLKS_PER_BAUD / 2;

    logic             rxd_meta;
    logic             rxd_sync;
    logic             rxd_prev;
    uart_state_e      state;
    logic [CNT_W-1:0] baud_cnt;
    logic [2:0]       bit_idx;
    pixel_t           shift_reg;
    logic             baud_end;

    // two flop synchronizer, then one more flop for edge detection
    always_ff @(posedge clk_100mhz or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
            rxd_prev <= 1'b1;
        end else begin
            rxd_meta <= rxd_i;
            rxd_sync <= rxd_meta;
            rxd_prev <= rxd_sync;
        end
    end

    assign baud_end = (baud_cnt == CNT_W'(CLKS_PER_BAUD - 1));

    always_ff @(posedge clk_100mhz or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state       <= UART_IDLE;
            baud_cnt    <= '0;
            bit_idx     <= '0;
            shift_reg   <= '0;
            valid_o     <= 1'b0;
            frame_err_o <= 1'b0;
        end else begin
            valid_o     <= 1'b0;
            frame_err_o <= 1'b0;
            case (state)
                UART_IDLE: begin
                    if (rxd_prev && !rxd_sync) begin   // falling edge, start bit begins
                        baud_cnt <= '0;
                        state    <= UART_START;
                    end
                end
                UART_START: begin
                    // wait half a bit so the later samples land mid bit
                    if (baud_cnt == CNT_W'(HALF_BAUD - 1)) begin
                        baud_cnt <= '0;
                        bit_idx  <= '0;
                        state    <= rxd_sync ? UART_IDLE : UART_DATA;   // high here is a glitch
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                UART_DATA: begin
                    if (baud_end) begin
                        baud_cnt  <= '0;
                        shift_reg <= {rxd_sync, shift_reg[7:1]};   // lsb first
                        bit_idx   <= bit_idx + 3'd1;
                        if (bit_idx == 3'd7) begin
                            state <= UART_STOP;
                        end
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                UART_STOP: begin
                    if (baud_end) begin
                        baud_cnt    <= '0;
                        valid_o     <= rxd_sync;
                        frame_err_o <= !rxd_sync;   // low stop bit, byte dropped
                        state       <= UART_IDLE;
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                default: state <= UART_IDLE;
            endcase
        end
    end

    assign data_o = shift_reg;

endmodule

// ==== source/pixel_stream_if.sv ====
`timescale 1ns/1ps

interface pixel_stream_if import downscale_pkg::*; ();

    pixel_t pix;     // pixel value
    coord_t x;       // column of the pixel
    coord_t y;       // row of the pixel
    logic   valid;   // single cycle strobe

    // raster counter drives the stream
    modport source (
        output pix,
        output x,
        output y,
        output valid
    );

    // pair summer and line buffer both listen
    modport sink (
        input pix,
        input x,
        input y,
        input valid
    );

endinterface

// ==== source/downscale_pkg.sv ====
package downscale_pkg;

    // bit widths of the values that travel through the design
    localparam int PIXEL_W = 8;
    localparam int COORD_W = 11;                // same width as the column and row counters
    localparam int PAIR_SUM_W = PIXEL_W + 1;
    localparam int BLOCK_SUM_W = PIXEL_W + 2;   // four pixels of 255 still fit

    // one grayscale pixel
    typedef logic [PIXEL_W-1:0] pixel_t;

    // column or row index
    typedef logic [COORD_W-1:0] coord_t;

    // sum of two horizontally adjacent pixels
    typedef logic [PAIR_SUM_W-1:0] pair_sum_t;

    // sum of a full 2x2 block
    typedef logic [BLOCK_SUM_W-1:0] block_sum_t;

    // shared by the receiver and the transmitter FSMs
    typedef enum logic [1:0] {
        UART_IDLE,
        UART_START,
        UART_DATA,
        UART_STOP
    } uart_state_e;

endpackage
